//--- logic/soc_pkg.sv
package soc_pkg;

  // ----------------------------------------------------------
  // Bus widths and address map
  // ----------------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;

  // Word address of the data RAM, 4096 words
  localparam int RAM_ADDR_W = 12;

  // Region in HADDR[31:28]
  localparam logic [3:0] REGION_RAM    = 4'h2;
  localparam logic [3:0] REGION_PERIPH = 4'h4;

  // Peripheral in HADDR[15:12]
  localparam logic [3:0] PERIPH_UART = 4'h0;
  localparam logic [3:0] PERIPH_LED  = 4'h1;

  // ----------------------------------------------------------
  // UART
  // ----------------------------------------------------------
  localparam logic [3:0] UART_DATA_OFS = 4'h0;
  localparam logic [3:0] UART_STAT_OFS = 4'h4;

  // Clock cycles per serial bit
  localparam int BAUD_DIV   = 16;
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

  // ----------------------------------------------------------
  // AHB encodings
  // ----------------------------------------------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Address phase control from the master
  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    logic [1:0]        htrans;
    logic [2:0]        hsize;
    logic              hwrite;
  } ahb_req_t;

  // Data phase response of a slave
  typedef struct packed {
    logic [DATA_W-1:0] hrdata;
    logic              hreadyout;
    logic              hresp;
  } ahb_resp_t;

  typedef enum logic [1:0] {RAM, UART, LED, NONE} slave_sel_t;

endpackage

//--- logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk,
  input  logic       RSTn,
  input  logic       rxd,
  output logic [7:0] rx_data,
  output logic       rx_valid
);
  import soc_pkg::*;

  enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} state;
  logic                  rxd_s1;
  logic                  rxd_s2;
  logic                  rxd_prev;
  logic [BAUD_CNT_W-1:0] cnt;
  logic [2:0]            bit_idx;
  logic                  half_bit;
  logic                  full_bit;

  // Synchronizer, third stage only for edge detection
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rxd_s1   <= 1'b1;
      rxd_s2   <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_s1   <= rxd;
      rxd_s2   <= rxd_s1;
      rxd_prev <= rxd_s2;
    end
  end

  assign half_bit = (cnt == BAUD_CNT_W'(BAUD_DIV/2 - 1));
  assign full_bit = (cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  // ----------------------------------------------------------
  // Frame FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      cnt      <= cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (rxd_prev && !rxd_s2) state <= RX_START;
        end
        RX_START: if (half_bit) begin
          cnt     <= '0;
          bit_idx <= '0;
          // Line back high at mid start bit, a glitch
          state   <= rxd_s2 ? RX_IDLE : RX_DATA;
        end
        RX_DATA: if (full_bit) begin
          cnt     <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= RX_STOP;
        end
        RX_STOP: if (full_bit) begin
          cnt      <= '0;
          rx_valid <= rxd_s2;
          state    <= RX_IDLE;
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && full_bit) begin
      rx_data <= {rxd_s2, rx_data[7:1]};
    end
  end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       RSTn,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       txd
);
  import soc_pkg::*;

  logic [9:0]            frame;
  logic [BAUD_CNT_W-1:0] cnt;
  logic [3:0]            bit_cnt;
  logic                  bit_end;

  assign bit_end = (cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  // ----------------------------------------------------------
  // Frame shifter
  // ----------------------------------------------------------
  // Stop bit, data LSB first, start bit at the bottom.
  // Ones shift in behind, so the line idles high.
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      frame   <= '1;
      cnt     <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        frame   <= {1'b1, tx_byte, 1'b0};
        cnt     <= '0;
        bit_cnt <= '0;
        tx_busy <= 1'b1;
      end
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      if (bit_end) begin
        frame   <= {1'b1, frame[9:1]};
        bit_cnt <= bit_cnt + 1'b1;
        // Last bit time is the stop bit
        if (bit_cnt == 4'd9) begin
          tx_busy <= 1'b0;
        end
      end
    end
  end

  assign txd = frame[0];

  a_idle_high: assert property (@(posedge clk) disable iff (!RSTn)
    !tx_busy |-> txd);

endmodule

//--- logic/ahb_fabric.sv
`timescale 1ns/1ps

module ahb_fabric (
  input  logic               clk,
  input  logic               RSTn,
  input  soc_pkg::ahb_req_t  req,
  output logic               hsel_ram,
  output logic               hsel_uart,
  output logic               hsel_led,
  input  soc_pkg::ahb_resp_t resp_ram,
  input  soc_pkg::ahb_resp_t resp_uart,
  input  soc_pkg::ahb_resp_t resp_led,
  output soc_pkg::ahb_resp_t resp
);
  import soc_pkg::*;

  slave_sel_t dec_sel;
  slave_sel_t data_sel;
  enum logic [1:0] {ERR_IDLE, ERR_FIRST, ERR_SECOND} err_st;
  ahb_resp_t  err_resp;
  logic       hready;
  logic       bad_addr;

  assign hready = resp.hreadyout;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    dec_sel = NONE;
    if (req.haddr[31:28] == REGION_RAM && req.haddr[27:RAM_ADDR_W+2] == '0) begin
      dec_sel = RAM;
    end else if (req.haddr[31:28] == REGION_PERIPH && req.haddr[27:16] == '0) begin
      if (req.haddr[15:12] == PERIPH_UART) begin
        dec_sel = UART;
      end else if (req.haddr[15:12] == PERIPH_LED) begin
        dec_sel = LED;
      end
    end
  end

  assign hsel_ram  = (dec_sel == RAM);
  assign hsel_uart = (dec_sel == UART);
  assign hsel_led  = (dec_sel == LED);

  // Slave owning the current data phase
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      data_sel <= NONE;
    end else if (hready) begin
      data_sel <= dec_sel;
    end
  end

  // Default slave giving a two-cycle ERROR for unmapped transfers
  assign bad_addr = hready && dec_sel == NONE && req.htrans != HTRANS_IDLE;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      err_st <= ERR_IDLE;
    end else begin
      case (err_st)
        ERR_IDLE:   if (bad_addr) err_st <= ERR_FIRST;
        ERR_FIRST:  err_st <= ERR_SECOND;
        ERR_SECOND: err_st <= bad_addr ? ERR_FIRST : ERR_IDLE;
        default:    err_st <= ERR_IDLE;
      endcase
    end
  end

  always_comb begin
    err_resp.hrdata    = '0;
    err_resp.hreadyout = (err_st != ERR_FIRST);
    err_resp.hresp     = (err_st != ERR_IDLE);
  end

  // Response mux
  always_comb begin
    case (data_sel)
      RAM:     resp = resp_ram;
      UART:    resp = resp_uart;
      LED:     resp = resp_led;
      default: resp = err_resp;
    endcase
  end

  // ERROR wait cycle is always closed by a ready ERROR cycle
  a_err_two_cycle: assert property (@(posedge clk) disable iff (!RSTn)
    resp.hresp && !resp.hreadyout |=> resp.hresp && resp.hreadyout);

endmodule

//--- logic/ahb_bram.sv
`timescale 1ns/1ps

module ahb_bram (
  input  logic                       clk,
  input  logic                       RSTn,
  input  logic                       hsel,
  input  soc_pkg::ahb_req_t          req,
  input  logic                       hready,
  input  logic [soc_pkg::DATA_W-1:0] hwdata,
  output soc_pkg::ahb_resp_t         resp
);
  import soc_pkg::*;

  logic [DATA_W-1:0]     mem [0:(1<<RAM_ADDR_W)-1];
  logic [RAM_ADDR_W-1:0] word_addr;
  logic [RAM_ADDR_W-1:0] wr_addr;
  logic [3:0]            wr_be;
  logic                  wr_pend;
  logic                  acc;
  logic                  rd_en;
  logic                  wr_en;
  logic [DATA_W-1:0]     rd_word;
  logic [DATA_W-1:0]     fwd_data;
  logic [3:0]            fwd_be;

  // Byte lanes touched by a transfer
  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] ofs);
    case (size)
      HSIZE_BYTE: lane_mask = 4'b0001 << ofs;
      HSIZE_HALF: lane_mask = ofs[1] ? 4'b1100 : 4'b0011;
      default:    lane_mask = 4'b1111;
    endcase
  endfunction

  assign word_addr = req.haddr[RAM_ADDR_W+1:2];
  assign acc       = hsel && hready && req.htrans == HTRANS_NONSEQ;
  assign rd_en     = acc && !req.hwrite;
  // Write lands at the edge closing its data phase
  assign wr_en     = wr_pend && hready;

  // ----------------------------------------------------------
  // Address phase capture
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_pend <= 1'b0;
    end else if (hready) begin
      wr_pend <= acc && req.hwrite;
    end
  end

  always_ff @(posedge clk) begin
    if (acc && req.hwrite) begin
      wr_addr <= word_addr;
      wr_be   <= lane_mask(req.hsize, req.haddr[1:0]);
    end
  end

  // ----------------------------------------------------------
  // Word array
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wr_en && wr_be[i]) begin
        mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
      end
    end
    if (rd_en) begin
      rd_word <= mem[word_addr];
    end
  end

  // Lanes of a write retiring at the same edge as the read
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      fwd_be <= '0;
    end else if (rd_en) begin
      fwd_be <= (wr_en && wr_addr == word_addr) ? wr_be : 4'b0000;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      fwd_data <= hwdata;
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      resp.hrdata[8*i +: 8] = fwd_be[i] ? fwd_data[8*i +: 8] : rd_word[8*i +: 8];
    end
    resp.hreadyout = 1'b1;
    resp.hresp     = 1'b0;
  end

  a_size_max: assert property (@(posedge clk) disable iff (!RSTn)
    hsel && req.htrans == HTRANS_NONSEQ |-> req.hsize <= HSIZE_WORD);

endmodule

//--- logic/ahb_led.sv
`timescale 1ns/1ps

module ahb_led (
  input  logic                       clk,
  input  logic                       RSTn,
  input  logic                       hsel,
  input  soc_pkg::ahb_req_t          req,
  input  logic                       hready,
  input  logic [soc_pkg::DATA_W-1:0] hwdata,
  output soc_pkg::ahb_resp_t         resp,
  output logic [7:0]                 led
);
  import soc_pkg::*;

  logic wr_pend;

  // Write flag from the address phase
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_pend <= 1'b0;
    end else if (hready) begin
      wr_pend <= hsel && req.htrans == HTRANS_NONSEQ && req.hwrite;
    end
  end

  // Load at the end of the data phase
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      led <= '0;
    end else if (wr_pend && hready) begin
      led <= hwdata[7:0];
    end
  end

  assign resp = '{hrdata: {{(DATA_W-8){1'b0}}, led}, hreadyout: 1'b1, hresp: 1'b0};

endmodule

//--- logic/ahb_uart.sv
`timescale 1ns/1ps

module ahb_uart (
  input  logic                       clk,
  input  logic                       RSTn,
  input  logic                       hsel,
  input  soc_pkg::ahb_req_t          req,
  input  logic                       hready,
  input  logic [soc_pkg::DATA_W-1:0] hwdata,
  output soc_pkg::ahb_resp_t         resp,
  input  logic                       rxd,
  output logic                       txd,
  output logic                       uart_irq
);
  import soc_pkg::*;

  logic       wr_q;
  logic [3:0] ofs_q;
  logic       tx_start;
  logic       tx_busy;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic [7:0] rx_hold;

  // Address phase capture
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_q  <= 1'b0;
      ofs_q <= '0;
    end else if (hready) begin
      wr_q  <= hsel && req.htrans == HTRANS_NONSEQ && req.hwrite;
      ofs_q <= req.haddr[3:0];
    end
  end

  // Writes while a frame is going out are dropped
  assign tx_start = wr_q && hready && ofs_q == UART_DATA_OFS && !tx_busy;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rx_hold <= '0;
    end else if (rx_valid) begin
      rx_hold <= rx_data;
    end
  end

  always_comb begin
    resp.hrdata = '0;
    if (ofs_q == UART_STAT_OFS) begin
      resp.hrdata[0] = tx_busy;
    end else if (ofs_q == UART_DATA_OFS) begin
      resp.hrdata[7:0] = rx_hold;
    end
    resp.hreadyout = 1'b1;
    resp.hresp     = 1'b0;
  end

  assign uart_irq = rx_valid;

  uart_rx u_rx (
    .clk      (clk),
    .RSTn     (RSTn),
    .rxd      (rxd),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  uart_tx u_tx (
    .clk      (clk),
    .RSTn     (RSTn),
    .tx_start (tx_start),
    .tx_byte  (hwdata[7:0]),
    .tx_busy  (tx_busy),
    .txd      (txd)
  );

endmodule

//--- logic/ahb_soc.sv
`timescale 1ns/1ps

module ahb_soc (
  input  logic                       clk,
  input  logic                       RSTn,
  input  soc_pkg::ahb_req_t          bus_req,
  input  logic [soc_pkg::DATA_W-1:0] hwdata,
  output soc_pkg::ahb_resp_t         bus_resp,
  input  logic                       rxd,
  output logic                       txd,
  output logic [7:0]                 led,
  output logic                       uart_irq
);
  import soc_pkg::*;

  logic      hsel_ram;
  logic      hsel_uart;
  logic      hsel_led;
  logic      hready;
  ahb_resp_t resp_ram;
  ahb_resp_t resp_uart;
  ahb_resp_t resp_led;

  // Master and slaves see the same ready
  assign hready = bus_resp.hreadyout;

  // ----------------------------------------------------------
  // Fabric and slaves
  // ----------------------------------------------------------
  ahb_fabric u_fabric (
    .clk(clk), .RSTn(RSTn), .req(bus_req),
    .hsel_ram(hsel_ram), .hsel_uart(hsel_uart), .hsel_led(hsel_led),
    .resp_ram(resp_ram), .resp_uart(resp_uart), .resp_led(resp_led),
    .resp(bus_resp)
  );

  ahb_bram u_bram (
    .clk(clk), .RSTn(RSTn), .hsel(hsel_ram), .req(bus_req),
    .hready(hready), .hwdata(hwdata), .resp(resp_ram)
  );

  ahb_led u_led (
    .clk(clk), .RSTn(RSTn), .hsel(hsel_led), .req(bus_req),
    .hready(hready), .hwdata(hwdata), .resp(resp_led), .led(led)
  );

  ahb_uart u_uart (
    .clk(clk), .RSTn(RSTn), .hsel(hsel_uart), .req(bus_req),
    .hready(hready), .hwdata(hwdata), .resp(resp_uart),
    .rxd(rxd), .txd(txd), .uart_irq(uart_irq)
  );

endmodule

//--- testbench/soc_tb_checks.svh
`ifndef SOC_TB_CHECKS_SVH
`define SOC_TB_CHECKS_SVH

// ----------------------------------------------------------
// Error reporting, first error ends the run
// ----------------------------------------------------------
task automatic report_error(input string msg);
  $display("%s", msg);
  $display("tests failed");
  $fatal(1, "Simulation stopped at the first error");
endtask

// Read data of a completed transfer
task automatic check_data(input string what, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] got);
  if (got !== exp) begin
    report_error($sformatf("FAILED at %0t: %s, expected %h, got %h",
                           $time, what, exp, got));
  end
endtask

// Response kind only, hrdata is checked separately
task automatic check_resp(input string what, input ahb_resp_t exp, input ahb_resp_t got);
  if (got.hreadyout !== exp.hreadyout || got.hresp !== exp.hresp) begin
    report_error($sformatf("FAILED at %0t: %s, expected hreadyout %b hresp %b, got %b %b",
                           $time, what, exp.hreadyout, exp.hresp,
                           got.hreadyout, got.hresp));
  end
endtask

// LED value and serial bytes
task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
  if (got !== exp) begin
    report_error($sformatf("FAILED at %0t: %s, expected %h, got %h",
                           $time, what, exp, got));
  end
endtask

`endif

//--- testbench/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;
  import soc_pkg::*;

  `include "soc_tb_checks.svh"

  localparam int CLK_NS  = 8;
  localparam int BIT_NS  = BAUD_DIV * CLK_NS;
  localparam int N_PRE   = 64;
  localparam int N_RAM   = 300;
  localparam int N_LED   = 10;
  localparam int N_TX    = 8;
  localparam int N_RX    = 8;
  localparam int N_ERR   = 10;
  localparam int N_XFER  = N_PRE + N_RAM + 2 * N_LED + 2 * N_TX + N_RX + 2 * N_ERR;
  localparam int N_FRAME = N_TX + N_RX;
  localparam int WD_CYCLES = N_XFER * 4 + N_FRAME * 12 * BAUD_DIV + 1000;

  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] LED_BASE  = 32'h4000_1000;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic              write;
    logic [DATA_W-1:0] wdata;
    logic              exp_err;
    logic              is_ram;
  } xfer_t;

  logic              clk;
  logic              RSTn;
  ahb_req_t          bus_req;
  logic [DATA_W-1:0] hwdata;
  ahb_resp_t         bus_resp;
  logic              rxd;
  logic              txd;
  logic [7:0]        led;
  logic              uart_irq;

  xfer_t             xq[$];
  logic [7:0]        ram_model[logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] last_rdata;
  logic [7:0]        tx_got[$];
  int                irq_cnt;

  ahb_soc DUT (
    .clk(clk), .RSTn(RSTn), .bus_req(bus_req), .hwdata(hwdata),
    .bus_resp(bus_resp), .rxd(rxd), .txd(txd), .led(led), .uart_irq(uart_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    report_error($sformatf("Timeout: the run did not finish within %0d clock cycles",
                           WD_CYCLES));
  end

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  task automatic queue_xfer(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                            input logic write, input logic [DATA_W-1:0] wdata,
                            input logic exp_err, input logic is_ram);
    xq.push_back('{addr: addr, size: size, write: write, wdata: wdata,
                   exp_err: exp_err, is_ram: is_ram});
  endtask

  // Update or check the RAM model when a data phase ends
  task automatic retire(input xfer_t d, input logic [DATA_W-1:0] data);
    int                nbytes;
    int                lane;
    logic [ADDR_W-1:0] start;
    logic [ADDR_W-1:0] ba;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] got;
    // Bytes of an aligned transfer, each on the lane of its own address
    nbytes = 1 << d.size;
    start  = d.addr & ~ADDR_W'(nbytes - 1);
    exp    = '0;
    got    = '0;
    last_rdata = data;
    if (d.is_ram) begin
      for (int k = 0; k < nbytes; k++) begin
        ba   = start + ADDR_W'(k);
        lane = int'(ba[1:0]);
        if (d.write) begin
          ram_model[ba] = d.wdata[8*lane +: 8];
        end else begin
          exp[8*lane +: 8] = ram_model[ba];
          got[8*lane +: 8] = data[8*lane +: 8];
        end
      end
      if (!d.write) check_data($sformatf("RAM read at %h", d.addr), exp, got);
    end
  endtask

  // ----------------------------------------------------------
  // Pipelined bus driver with one address and one data phase
  // ----------------------------------------------------------
  task automatic run_xfers();
    xfer_t a;
    xfer_t d;
    logic  a_v;
    logic  d_v;
    logic  advance;
    logic  rdy;
    logic  err_wait;
    a = '0;
    d = '0;
    a_v = 1'b0;
    d_v = 1'b0;
    advance = 1'b1;
    err_wait = 1'b0;
    while (xq.size() > 0 || a_v || d_v) begin
      @(posedge clk);
      if (advance) begin
        d   = a;
        d_v = a_v;
        hwdata <= (a_v && a.write) ? a.wdata : '0;
        if (xq.size() > 0) begin
          a   = xq.pop_front();
          a_v = 1'b1;
          bus_req <= '{haddr: a.addr, htrans: HTRANS_NONSEQ, hsize: a.size, hwrite: a.write};
        end else begin
          a_v = 1'b0;
          bus_req <= '{haddr: '0, htrans: HTRANS_IDLE, hsize: HSIZE_WORD, hwrite: 1'b0};
        end
      end
      @(negedge clk);
      rdy = bus_resp.hreadyout;
      if (d_v && d.exp_err) begin
        if (!rdy) begin
          check_resp("first ERROR cycle", '{hrdata: '0, hreadyout: 1'b0, hresp: 1'b1},
                     bus_resp);
          err_wait = 1'b1;
        end else begin
          check_resp("second ERROR cycle", '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b1},
                     bus_resp);
          if (!err_wait) report_error("Unmapped access ended without its wait cycle");
          err_wait = 1'b0;
        end
      end else if (d_v) begin
        check_resp("OKAY response", '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b0}, bus_resp);
      end
      if (d_v && rdy) begin
        if (!d.exp_err) retire(d, bus_resp.hrdata);
        d_v = 1'b0;
      end
      advance = rdy;
    end
  endtask

  // Serial frame on rxd with the LSB first
  task automatic send_serial(input logic [7:0] b);
    logic [9:0] f;
    f = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rxd <= f[i];
      repeat (BAUD_DIV - 1) @(posedge clk);
    end
    repeat (BAUD_DIV) @(posedge clk);
  endtask

  // Decode txd at bit centers counted from the start edge
  initial begin : tx_decode
    logic [7:0] b;
    forever begin
      @(negedge txd);
      #(BIT_NS / 2);
      if (txd !== 1'b0) report_error("Start bit on txd did not stay low to its middle");
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        b[i] = txd;
      end
      #(BIT_NS);
      if (txd !== 1'b1) report_error("Stop bit on txd was not high");
      tx_got.push_back(b);
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (uart_irq === 1'b1) irq_cnt++;
    end
  end

  initial begin : main
    logic [ADDR_W-1:0] a;
    logic [2:0]        sz;
    logic [1:0]        ofs;
    logic [7:0]        v;
    logic              prev_wr;
    void'($urandom(32'h9e25e7e5));
    RSTn       = 1'b0;
    bus_req    = '{haddr: '0, htrans: HTRANS_IDLE, hsize: HSIZE_WORD, hwrite: 1'b0};
    hwdata     = '0;
    rxd        = 1'b1;
    last_rdata = '0;
    irq_cnt    = 0;
    prev_wr    = 1'b0;
    a          = RAM_BASE;
    repeat (8) @(posedge clk);
    RSTn <= 1'b1;
    @(negedge clk);
    check_resp("response after reset", '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b0}, bus_resp);
    check_byte("led after reset", 8'h00, led);
    if (txd !== 1'b1 || uart_irq !== 1'b0) begin
      report_error($sformatf("FAILED at %0t: after reset expected txd 1 uart_irq 0, got %b %b",
                             $time, txd, uart_irq));
    end

    // ----------------------------------------------------------
    // Preload the RAM window before the random traffic
    // ----------------------------------------------------------
    for (int w = 0; w < N_PRE; w++) begin
      a = RAM_BASE + ADDR_W'(4 * w);
      queue_xfer(a, HSIZE_WORD, 1'b1, fill_word(a), 1'b0, 1'b1);
    end
    for (int n = 0; n < N_RAM; n++) begin
      if (prev_wr && $urandom_range(2) == 0) begin
        // Read straight back the word just written
        queue_xfer({a[ADDR_W-1:2], 2'b00}, HSIZE_WORD, 1'b0, '0, 1'b0, 1'b1);
        prev_wr = 1'b0;
      end else begin
        sz  = 3'($urandom_range(2));
        ofs = 2'($urandom_range(3));
        if (sz == HSIZE_HALF) ofs[0] = 1'b0;
        if (sz == HSIZE_WORD) ofs = 2'b00;
        a = RAM_BASE + ADDR_W'(4 * $urandom_range(N_PRE - 1)) + ADDR_W'(ofs);
        prev_wr = 1'($urandom_range(1));
        queue_xfer(a, sz, prev_wr, $urandom, 1'b0, 1'b1);
      end
    end
    run_xfers();

    // LED write and read back
    for (int n = 0; n < N_LED; n++) begin
      v = 8'($urandom);
      queue_xfer(LED_BASE, HSIZE_WORD, 1'b1, {24'($urandom), v}, 1'b0, 1'b0);
      queue_xfer(LED_BASE, HSIZE_WORD, 1'b0, '0, 1'b0, 1'b0);
      run_xfers();
      check_byte("led port", v, led);
      check_byte("led read back", v, last_rdata[7:0]);
    end

    // ----------------------------------------------------------
    // UART transmit with a second write landing while busy
    // ----------------------------------------------------------
    for (int n = 0; n < N_TX; n++) begin
      v = 8'($urandom);
      queue_xfer(UART_BASE + 32'(UART_DATA_OFS), HSIZE_WORD, 1'b1, 32'(v), 1'b0, 1'b0);
      queue_xfer(UART_BASE + 32'(UART_DATA_OFS), HSIZE_WORD, 1'b1, 32'(~v), 1'b0, 1'b0);
      run_xfers();
      do begin
        queue_xfer(UART_BASE + 32'(UART_STAT_OFS), HSIZE_WORD, 1'b0, '0, 1'b0, 1'b0);
        run_xfers();
      end while (last_rdata[0] !== 1'b0);
      if (tx_got.size() != 1) begin
        report_error($sformatf("FAILED at %0t: expected one txd frame, decoded %0d",
                               $time, tx_got.size()));
      end
      check_byte("txd byte", v, tx_got.pop_front());
    end
    repeat (12 * BAUD_DIV) @(posedge clk);
    if (tx_got.size() != 0) report_error("A write while busy sent an extra frame on txd");

    // UART receive
    for (int n = 0; n < N_RX; n++) begin
      v = 8'($urandom);
      irq_cnt = 0;
      send_serial(v);
      repeat (4) @(posedge clk);
      if (irq_cnt != 1) begin
        report_error($sformatf("FAILED at %0t: expected one uart_irq pulse, saw %0d",
                               $time, irq_cnt));
      end
      queue_xfer(UART_BASE + 32'(UART_DATA_OFS), HSIZE_WORD, 1'b0, '0, 1'b0, 1'b0);
      run_xfers();
      check_byte("received byte", v, last_rdata[7:0]);
    end

    // Unmapped access followed by a RAM read
    for (int n = 0; n < N_ERR; n++) begin
      a = $urandom;
      if (a[31:28] == REGION_RAM || a[31:28] == REGION_PERIPH) a[31:28] = 4'hc;
      if (n % 2 == 1) a = {REGION_PERIPH, 12'h000, 4'h7, 12'($urandom)};
      a[1:0] = 2'b00;
      queue_xfer(a, HSIZE_WORD, 1'($urandom_range(1)), $urandom, 1'b1, 1'b0);
      queue_xfer(RAM_BASE + ADDR_W'(4 * $urandom_range(N_PRE - 1)), HSIZE_WORD, 1'b0, '0,
                 1'b0, 1'b1);
      run_xfers();
    end

    $display("all tests passed");
    $finish;
  end

endmodule

//--- ahb_soc.f
+incdir+testbench
logic/soc_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/ahb_fabric.sv
logic/ahb_bram.sv
logic/ahb_led.sv
logic/ahb_uart.sv
logic/ahb_soc.sv
testbench/soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module soc_tb -f ahb_soc.f -o soc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/soc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit $status
fi

exit 0
